/* flist.f */
rtl/snes_load_pkg.sv
rtl/cart_header_detect.sv
rtl/ram_clear_fill.sv
rtl/cheat_code_latch.sv
rtl/audio_sat_mixer.sv
rtl/cart_load_top.sv
testbench/cart_load_chk.sv
testbench/tb_cart_load.sv

/* rtl/audio_sat_mixer.sv */
// Stereo mix of main and auxiliary audio
// Signed 17-bit add per channel, clamped to the 16-bit range
// Output registered, one cycle after the inputs
module audio_sat_mixer import snes_load_pkg::*; (
	input  logic          clk_sys,
	input  logic          RESET,
	input  audio_sample_t main_l,
	input  audio_sample_t main_r,
	input  audio_sample_t msu_l,
	input  audio_sample_t msu_r,
	output audio_sample_t audio_l,
	output audio_sample_t audio_r
);

	// Top two sum bits differ on overflow, bit 16 gives the direction
	function automatic audio_sample_t sat_add(input audio_sample_t a, input audio_sample_t b);
		logic [16:0] sum;
		sum = {a[15], a} + {b[15], b};
		if (sum[16] != sum[15])
			return sum[16] ? 16'h8000 : 16'h7FFF;
		else
			return sum[15:0];
	endfunction

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			audio_l <= '0;
			audio_r <= '0;
		end else begin
			audio_l <= sat_add(main_l, msu_l);
			audio_r <= sat_add(main_r, msu_r);
		end
	end

endmodule

/* rtl/cart_header_detect.sv */
// Cartridge header parser
// Word 0 of an auto-mode image carries {ram_size, rom_size} in its low byte
// and the map type in its high byte; word 2 bit 8 is the region flag
// Fixed header modes read the sizes at the mode's offset past the copier header
// Masks stay zero until the first header word has been seen
module cart_header_detect import snes_load_pkg::*; (
	input  logic         clk_sys,
	input  logic         RESET,
	input  logic         cart_active,
	input  dl_addr_t     ioctl_addr,
	input  dl_word_t     ioctl_dout,
	input  logic         ioctl_wr,
	input  header_mode_t header_mode,
	input  logic [1:0]   region_sel,
	output rom_type_t    rom_type,
	output addr_mask_t   rom_mask,
	output addr_mask_t   ram_mask,
	output size_code_t   ram_size,
	output logic         pal
);

	size_code_t rom_size;
	logic       rom_region;
	logic       hdr_seen;
	logic       hdr_wr;
	dl_addr_t   size_addr;
	logic       size_addr_en;

	assign hdr_wr = cart_active & ioctl_wr;

	// Location of the ROM size byte for the fixed modes
	always_comb begin
		size_addr    = '0;
		size_addr_en = 1'b1;
		case (header_mode)
			HDR_LOROM:   size_addr = HDR_LOROM_SIZE + COPIER_HDR_BYTES;
			HDR_HIROM:   size_addr = HDR_HIROM_SIZE + COPIER_HDR_BYTES;
			HDR_EXHIROM: size_addr = HDR_EXHIROM_SIZE + COPIER_HDR_BYTES;
			default:     size_addr_en = 1'b0;
		endcase
	end

	// ======================================
	// Header capture
	// ======================================
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			rom_type   <= '0;
			rom_size   <= '0;
			ram_size   <= '0;
			rom_region <= 1'b0;
			hdr_seen   <= 1'b0;
		end else if (hdr_wr) begin
			if (ioctl_addr == '0) begin
				hdr_seen <= 1'b1;
				rom_size <= DEFAULT_ROM_SIZE;
				ram_size <= '0;
				if (header_mode == HDR_AUTO && ioctl_dout[7:0] != 8'h00)
					{ram_size, rom_size} <= ioctl_dout[7:0];
				case (header_mode)
					HDR_NONE, HDR_LOROM: rom_type <= 8'h00;
					HDR_HIROM:           rom_type <= 8'h01;
					HDR_EXHIROM:         rom_type <= 8'h02;
					default:             rom_type <= ioctl_dout[15:8];
				endcase
			end
			if (ioctl_addr == dl_addr_t'(2))
				rom_region <= ioctl_dout[8];
			if (size_addr_en) begin
				if (ioctl_addr == size_addr)
					rom_size <= ioctl_dout[11:8];
				// RAM size sits one word after the ROM size
				if (ioctl_addr == size_addr + dl_addr_t'(2))
					ram_size <= ioctl_dout[3:0];
			end
		end
	end

	// Region is only switched outside a download
	always_ff @(posedge clk_sys) begin
		if (RESET)
			pal <= 1'b0;
		else if (!cart_active)
			pal <= (region_sel == 2'b00) ? rom_region : region_sel[1];
	end

	// ======================================
	// Address masks, 1 KiB << size, minus one
	// ======================================
	assign rom_mask = hdr_seen ? (addr_mask_t'(1024) << rom_size) - addr_mask_t'(1) : '0;
	assign ram_mask = (ram_size != '0) ?
		(addr_mask_t'(1024) << ram_size) - addr_mask_t'(1) : '0;

endmodule

/* rtl/cart_load_top.sv */
// Cartridge-load front end with audio output stage
// Download index 1 (low six bits) or 0 is a cartridge, all ones is a cheat
// The core is held in reset during a cartridge download and the RAM clear
module cart_load_top import snes_load_pkg::*; (
	input  logic          clk_sys,
	input  logic          RESET,
	input  logic          ioctl_download,
	input  dl_index_t     ioctl_index,
	input  dl_addr_t      ioctl_addr,
	input  dl_word_t      ioctl_dout,
	input  logic          ioctl_wr,
	input  header_mode_t  header_mode,
	input  logic [1:0]    region_sel,
	input  init_pattern_t wram_init,
	input  init_pattern_t aram_init,
	input  audio_sample_t main_l,
	input  audio_sample_t main_r,
	input  audio_sample_t msu_l,
	input  audio_sample_t msu_r,
	output rom_type_t     rom_type,
	output addr_mask_t    rom_mask,
	output addr_mask_t    ram_mask,
	output size_code_t    ram_size,
	output logic          pal,
	output logic          clearing,
	output logic          fill_we,
	output fill_addr_t    fill_addr,
	output mem_byte_t     wram_fill_data,
	output mem_byte_t     aram_fill_data,
	output cheat_code_t   cheat_code,
	output logic          code_strobe,
	output audio_sample_t audio_l,
	output audio_sample_t audio_r,
	output logic          core_hold_reset
);

	logic cart_active;
	logic code_active;

	// ======================================
	// Download kind
	// ======================================
	assign cart_active = ioctl_download &
		((ioctl_index[5:0] == IDX_CART[5:0]) | (ioctl_index == '0));
	assign code_active = ioctl_download & (ioctl_index == IDX_CODE);

	assign core_hold_reset = RESET | cart_active | clearing;

	cart_header_detect u_cart_header_detect (
		.clk_sys     (clk_sys),
		.RESET       (RESET),
		.cart_active (cart_active),
		.ioctl_addr  (ioctl_addr),
		.ioctl_dout  (ioctl_dout),
		.ioctl_wr    (ioctl_wr),
		.header_mode (header_mode),
		.region_sel  (region_sel),
		.rom_type    (rom_type),
		.rom_mask    (rom_mask),
		.ram_mask    (ram_mask),
		.ram_size    (ram_size),
		.pal         (pal)
	);

	ram_clear_fill u_ram_clear_fill (
		.clk_sys        (clk_sys),
		.RESET          (RESET),
		.cart_active    (cart_active),
		.wram_init      (wram_init),
		.aram_init      (aram_init),
		.clearing       (clearing),
		.fill_we        (fill_we),
		.fill_addr      (fill_addr),
		.wram_fill_data (wram_fill_data),
		.aram_fill_data (aram_fill_data)
	);

	cheat_code_latch u_cheat_code_latch (
		.clk_sys     (clk_sys),
		.RESET       (RESET),
		.code_active (code_active),
		.ioctl_addr  (ioctl_addr),
		.ioctl_dout  (ioctl_dout),
		.ioctl_wr    (ioctl_wr),
		.cheat_code  (cheat_code),
		.code_strobe (code_strobe)
	);

	audio_sat_mixer u_audio_sat_mixer (
		.clk_sys (clk_sys),
		.RESET   (RESET),
		.main_l  (main_l),
		.main_r  (main_r),
		.msu_l   (msu_l),
		.msu_r   (msu_r),
		.audio_l (audio_l),
		.audio_r (audio_r)
	);

endmodule

/* rtl/cheat_code_latch.sv */
// Cheat code assembly from the code download stream
// Eight word writes per code, selected by the low address nibble
// Layout is {flags, address, compare, replace}, 32 bits each, low word first
module cheat_code_latch import snes_load_pkg::*; (
	input  logic        clk_sys,
	input  logic        RESET,
	input  logic        code_active,
	input  dl_addr_t    ioctl_addr,
	input  dl_word_t    ioctl_dout,
	input  logic        ioctl_wr,
	output cheat_code_t cheat_code,
	output logic        code_strobe
);

	logic code_wr;

	assign code_wr = code_active & ioctl_wr;

	always_ff @(posedge clk_sys) begin
		if (code_wr) begin
			case (ioctl_addr[3:0])
				4'd0:  cheat_code[111:96]  <= ioctl_dout;
				4'd2:  cheat_code[127:112] <= ioctl_dout;
				4'd4:  cheat_code[79:64]   <= ioctl_dout;
				4'd6:  cheat_code[95:80]   <= ioctl_dout;
				4'd8:  cheat_code[47:32]   <= ioctl_dout;
				4'd10: cheat_code[63:48]   <= ioctl_dout;
				4'd12: cheat_code[15:0]    <= ioctl_dout;
				4'd14: cheat_code[31:16]   <= ioctl_dout;
				default: ;
			endcase
		end
	end

	// Replace high word completes the code
	always_ff @(posedge clk_sys) begin
		if (RESET)
			code_strobe <= 1'b0;
		else
			code_strobe <= code_wr && (ioctl_addr[3:0] == 4'd14);
	end

endmodule

/* rtl/ram_clear_fill.sv */
// Work and audio RAM clear on cartridge download start
// One write strobe every second cycle over 2^18 addresses, no back-pressure
// A download start seen while a clear is running is ignored
module ram_clear_fill import snes_load_pkg::*; (
	input  logic          clk_sys,
	input  logic          RESET,
	input  logic          cart_active,
	input  init_pattern_t wram_init,
	input  init_pattern_t aram_init,
	output logic          clearing,
	output logic          fill_we,
	output fill_addr_t    fill_addr,
	output mem_byte_t     wram_fill_data,
	output mem_byte_t     aram_fill_data
);

	clear_state_t state;
	logic         cart_active_d;
	logic         start;

	// Rising edge of the cartridge download
	always_ff @(posedge clk_sys) begin
		if (RESET)
			cart_active_d <= 1'b0;
		else
			cart_active_d <= cart_active;
	end

	assign start = cart_active & ~cart_active_d;

	// ======================================
	// Sweep sequencer
	// ======================================
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			state     <= CLR_IDLE;
			fill_addr <= '0;
		end else begin
			case (state)
				CLR_IDLE: begin
					if (start) begin
						state     <= CLR_WRITE;
						fill_addr <= '0;
					end
				end
				CLR_WRITE: begin
					// Last strobe ends the clear
					if (&fill_addr)
						state <= CLR_IDLE;
					else
						state <= CLR_WAIT;
				end
				CLR_WAIT: begin
					state     <= CLR_WRITE;
					fill_addr <= fill_addr + fill_addr_t'(1);
				end
				default: state <= CLR_IDLE;
			endcase
		end
	end

	assign clearing = (state != CLR_IDLE);
	assign fill_we  = (state == CLR_WRITE);

	// Pattern bytes track the current sweep address
	assign wram_fill_data = fill_pattern(wram_init, fill_addr);
	assign aram_fill_data = fill_pattern(aram_init, fill_addr);

endmodule

/* rtl/snes_load_pkg.sv */
// Shared types and constants for the cartridge-load front end
// Header offsets assume a 512-byte copier header ahead of the ROM image
// Fill patterns follow the start-up RAM contents of the console variants
package snes_load_pkg;

	// ======================================
	// Field types
	// ======================================
	typedef logic [7:0]          dl_index_t;
	typedef logic [24:0]         dl_addr_t;
	typedef logic [15:0]         dl_word_t;
	typedef logic [7:0]          rom_type_t;
	typedef logic [3:0]          size_code_t;
	typedef logic [23:0]         addr_mask_t;
	typedef logic [17:0]         fill_addr_t;
	typedef logic [7:0]          mem_byte_t;
	typedef logic [127:0]        cheat_code_t;
	typedef logic signed [15:0]  audio_sample_t;
	typedef logic [1:0]          init_pattern_t;

	typedef enum logic [2:0] {
		HDR_AUTO    = 3'd0,
		HDR_NONE    = 3'd1,
		HDR_LOROM   = 3'd2,
		HDR_HIROM   = 3'd3,
		HDR_EXHIROM = 3'd4
	} header_mode_t;

	typedef enum logic [1:0] {
		CLR_IDLE,
		CLR_WRITE,
		CLR_WAIT
	} clear_state_t;

	// ======================================
	// Download indices and header layout
	// ======================================
	localparam dl_index_t  IDX_CART         = 8'h01;
	localparam dl_index_t  IDX_CODE         = 8'hFF;
	localparam dl_addr_t   COPIER_HDR_BYTES = 25'd512;
	localparam dl_addr_t   HDR_LOROM_SIZE   = 25'h007FD6;
	localparam dl_addr_t   HDR_HIROM_SIZE   = 25'h00FFD6;
	localparam dl_addr_t   HDR_EXHIROM_SIZE = 25'h40FFD6;
	localparam size_code_t DEFAULT_ROM_SIZE = 4'hC;

	// Start-up RAM byte for a given pattern select and address
	function automatic mem_byte_t fill_pattern(input init_pattern_t sel, input fill_addr_t addr);
		mem_byte_t val;
		case (sel)
			2'd0: val = (addr[8] ^ addr[2]) ? 8'h66 : 8'h99;
			2'd1: val = (addr[9] ^ addr[0]) ? 8'hFF : 8'h00;
			2'd2: val = 8'h55;
			default: val = 8'hFF;
		endcase
		return val;
	endfunction

endpackage

/* run_sim.sh */
#!/bin/sh
# Build and run the cartridge-load testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_cart_load -f flist.f -o Vtb_cart_load
./obj_dir/Vtb_cart_load > sim.log 2>&1 || true
cat sim.log

if grep -qx "Done: no errors" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi

/* testbench/cart_load_chk.sv */
// Assertions on the cartridge-load top level
// Bound into every cart_load_top instance, disabled while RESET is high
module cart_load_chk (
	input logic clk_sys,
	input logic RESET,
	input logic clearing,
	input logic fill_we,
	input logic code_strobe,
	input logic core_hold_reset
);

	// Fill strobes only inside a clear, never back to back
	fill_in_clear: assert property (@(posedge clk_sys) disable iff (RESET)
		fill_we |-> clearing)
		else $error("fill_we high outside a clear");

	fill_spacing: assert property (@(posedge clk_sys) disable iff (RESET)
		fill_we |=> !fill_we)
		else $error("fill_we high on two consecutive cycles");

	code_pulse: assert property (@(posedge clk_sys) disable iff (RESET)
		code_strobe |=> !code_strobe)
		else $error("code_strobe longer than one cycle");

	// Core stays held for the whole clear
	hold_in_clear: assert property (@(posedge clk_sys) disable iff (RESET)
		clearing |-> core_hold_reset)
		else $error("core_hold_reset low during a clear");

endmodule

bind cart_load_top cart_load_chk u_cart_load_chk (
	.clk_sys         (clk_sys),
	.RESET           (RESET),
	.clearing        (clearing),
	.fill_we         (fill_we),
	.code_strobe     (code_strobe),
	.core_hold_reset (core_hold_reset)
);

/* testbench/cart_load_trace.txt */
# S idx mode region | W idx addr data | E | H type rom_mask ram_mask ram_size pal
# C flags addr cmp repl | A main_l msu_l main_r msu_r exp_l exp_r | N count | R
S 01 0 0
W 01 000000 0B15
W 01 000002 0100
E
H 0B 007FFF 0007FF 1 1
S 02 0 1
E
H 0B 007FFF 0007FF 1 0
S 02 0 2
E
H 0B 007FFF 0007FF 1 1
S 01 3 0
W 01 000000 0000
W 01 000002 0000
W 01 0101D6 0A00
W 01 0101D8 0003
E
H 01 0FFFFF 001FFF 3 0
S 01 4 0
W 01 000000 FFFF
W 01 4101D6 0C00
W 01 4101D8 0000
E
H 02 3FFFFF 000000 0 0
S FF 0 0
W FF 000000 1111
W FF 000002 2222
W FF 000004 3333
W FF 000006 4444
W FF 000008 5555
W FF 00000A 6666
W FF 00000C 7777
W FF 00000E 8888
C 22221111 44443333 66665555 88887777
E
A 1234 0100 F000 0800 1334 F800
A 7000 2000 9000 9000 7FFF 8000
N 20
R
R

/* testbench/tb_cart_load.sv */
// Trace-driven testbench for the cartridge-load front end
// Reads testbench/cart_load_trace.txt relative to the project root
// Random audio pairs and fill selects come from $urandom, seed 90537
// Inputs change 1 time unit after the rising edge, outputs are checked there too
// The run stops at the first mismatch
module tb_cart_load import snes_load_pkg::*; ();

	localparam int SEED          = 90537;
	localparam int CLEAR_STROBES = 1 << 18;

	logic          clk_sys;
	logic          RESET;
	logic          ioctl_download;
	dl_index_t     ioctl_index;
	dl_addr_t      ioctl_addr;
	dl_word_t      ioctl_dout;
	logic          ioctl_wr;
	header_mode_t  header_mode;
	logic [1:0]    region_sel;
	init_pattern_t wram_init;
	init_pattern_t aram_init;
	audio_sample_t main_l;
	audio_sample_t main_r;
	audio_sample_t msu_l;
	audio_sample_t msu_r;
	rom_type_t     rom_type;
	addr_mask_t    rom_mask;
	addr_mask_t    ram_mask;
	size_code_t    ram_size;
	logic          pal;
	logic          clearing;
	logic          fill_we;
	fill_addr_t    fill_addr;
	mem_byte_t     wram_fill_data;
	mem_byte_t     aram_fill_data;
	cheat_code_t   cheat_code;
	logic          code_strobe;
	audio_sample_t audio_l;
	audio_sample_t audio_r;
	logic          core_hold_reset;

	string lines[$];
	int    clear_count;
	int    watch_cycles;

	cart_load_top u_cart_load_top (.*);

	always #4 clk_sys = ~clk_sys;

	// ========================================
	// Failure reporting and compare tasks
	// ========================================
	task automatic report_failure(input string why);
		$display("%s", why);
		$display("Done: errors found");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_mask(input string name, input addr_mask_t got, input addr_mask_t exp);
		if (got !== exp)
			report_failure($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_type(input string name, input rom_type_t got, input rom_type_t exp);
		if (got !== exp)
			report_failure($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_size(input string name, input size_code_t got, input size_code_t exp);
		if (got !== exp)
			report_failure($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_addr(input string name, input fill_addr_t got, input fill_addr_t exp);
		if (got !== exp)
			report_failure($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_byte(input string name, input mem_byte_t got, input mem_byte_t exp);
		if (got !== exp)
			report_failure($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_code(input string name, input cheat_code_t got, input cheat_code_t exp);
		if (got !== exp)
			report_failure($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_sample(input string name, input audio_sample_t got,
			input audio_sample_t exp);
		if (got !== exp)
			report_failure($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			report_failure($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
	endtask

	// ========================================
	// Reference rules
	// ========================================
	function automatic mem_byte_t expected_fill(input init_pattern_t sel, input fill_addr_t addr);
		logic flip;
		mem_byte_t val;
		flip = 1'b0;
		if (sel == 2'd0)
			flip = ((addr >> 8) & 1) != ((addr >> 2) & 1);
		else if (sel == 2'd1)
			flip = ((addr >> 9) & 1) != (addr & 1);
		if (sel == 2'd0)
			val = flip ? 8'h66 : 8'h99;
		else if (sel == 2'd1)
			val = flip ? 8'hFF : 8'h00;
		else
			val = (sel == 2'd2) ? 8'h55 : 8'hFF;
		return val;
	endfunction

	function automatic audio_sample_t expected_mix(input audio_sample_t a, input audio_sample_t b);
		int total;
		total = int'(a) + int'(b);
		if (total > 32767)
			return 16'h7FFF;
		if (total < -32768)
			return 16'h8000;
		return audio_sample_t'(total);
	endfunction

	task automatic advance_cycle();
		@(posedge clk_sys);
		#1;
	endtask

	// Read all trace operations and count the clears
	task automatic load_trace();
		int    fd;
		string line;
		fd = $fopen("testbench/cart_load_trace.txt", "r");
		if (fd == 0) begin
			report_failure("Could not open the trace file testbench/cart_load_trace.txt");
		end else begin
			while (!$feof(fd)) begin
				line = "";
				void'($fgets(line, fd));
				if (line.len() > 0 && line[0] != "#" && line[0] != "\n") begin
					lines.push_back(line);
					if (line[0] == "S" || line[0] == "R")
						clear_count++;
				end
			end
			$fclose(fd);
		end
	endtask

	// Cartridge start, then the full sweep with random pattern selects
	task automatic run_clear();
		init_pattern_t w_sel;
		init_pattern_t a_sel;
		int            strobes;
		while (clearing)
			advance_cycle();
		w_sel = init_pattern_t'($urandom);
		a_sel = init_pattern_t'($urandom);
		strobes = 0;
		wram_init = w_sel;
		aram_init = a_sel;
		ioctl_index = IDX_CART;
		ioctl_download = 1'b1;
		advance_cycle();
		check_bit("clearing", clearing, 1'b1);
		check_bit("fill_we", fill_we, 1'b1);
		ioctl_download = 1'b0;
		while (clearing) begin
			check_bit("core_hold_reset", core_hold_reset, 1'b1);
			if (fill_we) begin
				check_addr("fill_addr", fill_addr, fill_addr_t'(strobes));
				check_byte("wram_fill_data", wram_fill_data,
					expected_fill(w_sel, fill_addr_t'(strobes)));
				check_byte("aram_fill_data", aram_fill_data,
					expected_fill(a_sel, fill_addr_t'(strobes)));
				strobes++;
			end
			advance_cycle();
		end
		if (strobes != CLEAR_STROBES)
			report_failure($sformatf("Clear ended after %0d fill strobes instead of %0d",
				strobes, CLEAR_STROBES));
		// Core released once the clear and the download are both over
		check_bit("core_hold_reset", core_hold_reset, 1'b0);
	endtask

	// ========================================
	// Trace operations
	// ========================================
	task automatic run_op(input string line);
		string       op;
		byte         opc;
		int          waited;
		logic [31:0] v0, v1, v2, v3, v4, v5;
		{v0, v1, v2, v3, v4, v5} = '0;
		op = "";
		void'($sscanf(line, "%s %h %h %h %h %h %h", op, v0, v1, v2, v3, v4, v5));
		opc = op[0];
		case (opc)
			"S": begin
				ioctl_index = dl_index_t'(v0);
				header_mode = header_mode_t'(v1[2:0]);
				region_sel = v2[1:0];
				ioctl_download = 1'b1;
				advance_cycle();
			end
			"W": begin
				ioctl_index = dl_index_t'(v0);
				ioctl_addr = dl_addr_t'(v1);
				ioctl_dout = dl_word_t'(v2);
				ioctl_wr = 1'b1;
				advance_cycle();
				ioctl_wr = 1'b0;
			end
			"E": begin
				ioctl_download = 1'b0;
				advance_cycle();
			end
			"H": begin
				check_type("rom_type", rom_type, rom_type_t'(v0));
				check_mask("rom_mask", rom_mask, addr_mask_t'(v1));
				check_mask("ram_mask", ram_mask, addr_mask_t'(v2));
				check_size("ram_size", ram_size, size_code_t'(v3));
				check_bit("pal", pal, v4[0]);
			end
			"C": begin
				waited = 0;
				while (!code_strobe && waited < 8) begin
					advance_cycle();
					waited++;
				end
				if (!code_strobe)
					report_failure("code_strobe did not rise after the last code word");
				check_code("cheat_code", cheat_code, {v0, v1, v2, v3});
			end
			"A": begin
				main_l = audio_sample_t'(v0);
				msu_l = audio_sample_t'(v1);
				main_r = audio_sample_t'(v2);
				msu_r = audio_sample_t'(v3);
				advance_cycle();
				check_sample("audio_l", audio_l, audio_sample_t'(v4));
				check_sample("audio_r", audio_r, audio_sample_t'(v5));
			end
			"N": begin
				repeat (v0) begin
					main_l = audio_sample_t'($urandom);
					msu_l = audio_sample_t'($urandom);
					main_r = audio_sample_t'($urandom);
					msu_r = audio_sample_t'($urandom);
					advance_cycle();
					check_sample("audio_l", audio_l, expected_mix(main_l, msu_l));
					check_sample("audio_r", audio_r, expected_mix(main_r, msu_r));
				end
			end
			"R": run_clear();
			default: report_failure($sformatf("Unknown trace operation in line %s", line));
		endcase
	endtask

	initial begin
		clk_sys = 1'b0;
		RESET = 1'b1;
		ioctl_download = 1'b0;
		ioctl_index = '0;
		ioctl_addr = '0;
		ioctl_dout = '0;
		ioctl_wr = 1'b0;
		header_mode = HDR_AUTO;
		region_sel = 2'b00;
		wram_init = '0;
		aram_init = '0;
		main_l = '0;
		main_r = '0;
		msu_l = '0;
		msu_r = '0;
		clear_count = 0;
		watch_cycles = 0;
		void'($urandom(SEED));
		load_trace();
		watch_cycles = 16 + lines.size() * 64 + clear_count * (1 << 19);
		repeat (16) @(posedge clk_sys);
		#1;
		RESET = 1'b0;
		foreach (lines[i])
			run_op(lines[i]);
		advance_cycle();
		$display("Done: no errors");
		$finish;
	end

	// Watchdog
	initial begin
		wait (watch_cycles > 0);
		repeat (watch_cycles) @(posedge clk_sys);
		report_failure($sformatf("Watchdog expired after %0d cycles, the run did not finish",
			watch_cycles));
	end

endmodule
